// ==== design/sc_fmt_pkg.sv ====
package sc_fmt_pkg;

   // complex sample, I in the upper half of the stream word, Q in the lower half
   localparam int SAMPLE_W = 16;
   localparam int WORD_W   = 2 * SAMPLE_W;

   localparam int I_HI = WORD_W - 1;
   localparam int I_LO = SAMPLE_W;
   localparam int Q_HI = SAMPLE_W - 1;
   localparam int Q_LO = 0;

   localparam int PROD_W = 2 * SAMPLE_W + 1;   // sum of two 16x16 products
   localparam int ACC_W  = 40;                 // window sums, PROD_W plus growth

   // P and R are scaled down before squaring so the products stay in CMP_W
   localparam int METRIC_SHIFT = 8;
   localparam int CMP_W        = 68;

endpackage

// ==== design/sc_cfg_pkg.sv ====
package sc_cfg_pkg;

   localparam int DELAY_LEN  = 16;                     // correlation lag
   localparam int WINDOW_LEN = 16;                     // averaging window
   localparam int WARMUP_LEN = DELAY_LEN + WINDOW_LEN; // metric valid after this

   // threshold of THRESH_NUM / THRESH_DEN on the normalized metric
   localparam int THRESH_NUM = 3;
   localparam int THRESH_DEN = 4;

   localparam int PLATEAU_MIN = 8;
   localparam int HOLDOFF_LEN = 64;

   localparam int DLY_AW = $clog2(DELAY_LEN);
   localparam int WIN_AW = $clog2(WINDOW_LEN);
   localparam int WARM_W = $clog2(WARMUP_LEN + 1);
   localparam int RUN_W  = 8;                          // covers plateau and holdoff

   typedef enum logic [1:0] {
      SEARCH,
      PLATEAU,
      HOLD
   } det_state_t;

endpackage

// ==== design/sc_delay_line.sv ====
module sc_delay_line
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,
   input  logic              i_en,
   input  logic [WORD_W-1:0] i_tdata,
   output logic [WORD_W-1:0] o_tdata
);

   logic [WORD_W-1:0] mem [DELAY_LEN];
   logic [DLY_AW-1:0] wr_ptr;
   logic              full;                  // every slot written since reset

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         wr_ptr <= '0;
         full   <= 1'b0;
      end else if (i_en) begin
         if (wr_ptr == DLY_AW'(DELAY_LEN - 1)) begin
            wr_ptr <= '0;
            full   <= 1'b1;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_en)
         mem[wr_ptr] <= i_tdata;             // oldest slot is overwritten
   end

   // slot under the pointer holds the word from DELAY_LEN beats ago
   assign o_tdata = full ? mem[wr_ptr] : '0;

endmodule

// ==== design/sc_corr_power.sv ====
module sc_corr_power
   import sc_fmt_pkg::*;
(
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_en,
   input  logic [WORD_W-1:0]        i_cur,
   input  logic [WORD_W-1:0]        i_dly,
   output logic signed [PROD_W-1:0] o_corr_i,
   output logic signed [PROD_W-1:0] o_corr_q,
   output logic [PROD_W-1:0]        o_pow
);

   logic signed [SAMPLE_W-1:0] cur_i;
   logic signed [SAMPLE_W-1:0] cur_q;
   logic signed [SAMPLE_W-1:0] dly_i;
   logic signed [SAMPLE_W-1:0] dly_q;

   assign cur_i = i_cur[I_HI:I_LO];
   assign cur_q = i_cur[Q_HI:Q_LO];
   assign dly_i = i_dly[I_HI:I_LO];
   assign dly_q = i_dly[Q_HI:Q_LO];

   // cur * conj(dly) = (ac + bd) + j(bc - ad)
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_corr_i <= '0;
         o_corr_q <= '0;
         o_pow    <= '0;
      end else if (i_en) begin
         o_corr_i <= cur_i * dly_i + cur_q * dly_q;
         o_corr_q <= cur_q * dly_i - cur_i * dly_q;
         o_pow    <= cur_i * cur_i + cur_q * cur_q;   // never above 2^31
      end
   end

endmodule

// ==== design/sc_moving_sum.sv ====
module sc_moving_sum
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
#(
   parameter int WIDTH = 33
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_clear,
   input  logic             i_en,
   input  logic [WIDTH-1:0] i_data,
   output logic [ACC_W-1:0] o_sum
);

   logic [WIDTH-1:0]  hist [WINDOW_LEN];
   logic [WIN_AW-1:0] ptr;
   logic              filled;               // window holds WINDOW_LEN inputs
   logic [WIDTH-1:0]  oldest;
   logic [ACC_W-1:0]  add_ext;
   logic [ACC_W-1:0]  sub_ext;

   assign oldest  = filled ? hist[ptr] : '0;
   assign add_ext = ACC_W'(signed'(i_data));   // sign extended
   assign sub_ext = ACC_W'(signed'(oldest));

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         ptr    <= '0;
         filled <= 1'b0;
         o_sum  <= '0;
      end else if (i_en) begin
         o_sum <= o_sum + add_ext - sub_ext;   // wraps in ACC_W bits
         if (ptr == WIN_AW'(WINDOW_LEN - 1)) begin
            ptr    <= '0;
            filled <= 1'b1;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_en)
         hist[ptr] <= i_data;
   end

endmodule

// ==== design/sc_sample_counter.sv ====
module sc_sample_counter
   import sc_cfg_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_clear,
   input  logic             i_beat,
   input  logic             i_run_clr,
   input  logic             i_run_inc,
   output logic             o_warm,
   output logic [RUN_W-1:0] o_run
);

   logic [WARM_W-1:0] warm_cnt;

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         warm_cnt <= '0;
         o_run    <= '0;
      end else begin
         if (i_beat && !o_warm)
            warm_cnt <= warm_cnt + 1'b1;           // saturates at WARMUP_LEN
         if (i_run_clr)
            o_run <= i_run_inc ? RUN_W'(1) : '0;  // clear and inc starts a run at 1
         else if (i_run_inc)
            o_run <= o_run + 1'b1;
      end
   end

   // high once WARMUP_LEN samples have passed the detector
   assign o_warm = (warm_cnt == WARM_W'(WARMUP_LEN));

endmodule

// ==== design/sc_detect_fsm.sv ====
module sc_detect_fsm
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_clear,
   input  logic             i_en,
   input  logic [ACC_W-1:0] i_p_i,
   input  logic [ACC_W-1:0] i_p_q,
   input  logic [ACC_W-1:0] i_r,
   input  logic             i_warm,
   input  logic [RUN_W-1:0] i_run,
   output logic             o_run_clr,
   output logic             o_run_inc,
   output logic             o_detect
);

   det_state_t               state_q, state_d;
   logic signed [CMP_W-1:0]  pi_x, pq_x, r_x;
   logic signed [CMP_W-1:0]  lhs, rhs;
   logic                     above;
   logic                     run_clr, run_inc, det_d;

   assign pi_x = CMP_W'(signed'(i_p_i) >>> METRIC_SHIFT);
   assign pq_x = CMP_W'(signed'(i_p_q) >>> METRIC_SHIFT);
   assign r_x  = CMP_W'(signed'(i_r) >>> METRIC_SHIFT);

   // |P|^2 / R^2 >= NUM / DEN without a divider
   assign lhs   = (pi_x * pi_x + pq_x * pq_x) * CMP_W'(THRESH_DEN);
   assign rhs   = (r_x * r_x) * CMP_W'(THRESH_NUM);
   assign above = i_warm && (lhs >= rhs);

   always_comb begin
      state_d = state_q;
      run_clr = 1'b0;
      run_inc = 1'b0;
      det_d   = 1'b0;
      case (state_q)
         SEARCH: begin
            if (above) begin
               state_d = PLATEAU;
               run_clr = 1'b1;                    // run restarts at 1
               run_inc = 1'b1;
            end
         end
         PLATEAU: begin
            if (!above) begin
               state_d = SEARCH;
               run_clr = 1'b1;
            end else if (i_run == RUN_W'(PLATEAU_MIN - 1)) begin
               state_d = HOLD;                    // this sample completes the plateau
               det_d   = 1'b1;
               run_clr = 1'b1;
            end else begin
               run_inc = 1'b1;
            end
         end
         HOLD: begin
            if (i_run == RUN_W'(HOLDOFF_LEN - 1)) begin
               state_d = SEARCH;
               run_clr = 1'b1;
            end else begin
               run_inc = 1'b1;
            end
         end
         default: state_d = SEARCH;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         state_q  <= SEARCH;
         o_detect <= 1'b0;
      end else if (i_en) begin
         state_q  <= state_d;
         o_detect <= det_d;                       // held while the stage stalls
      end
   end

   assign o_run_clr = i_en && run_clr;
   assign o_run_inc = i_en && run_inc;

endmodule

// ==== design/schmidl_cox.sv ====
module schmidl_cox
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,
   input  logic [WORD_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              i_tready,
   output logic [WORD_W-1:0] o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              o_tready,
   output logic              o_detect
);

   logic                     advance, accept, s2_en, s3_en;
   logic                     s1_valid, s2_valid;
   logic [WORD_W-1:0]        s1_data, s2_data, dly_data;
   logic                     s1_last, s2_last;
   logic signed [PROD_W-1:0] corr_i, corr_q;
   logic [PROD_W-1:0]        pow;
   logic [ACC_W-1:0]         p_i, p_q, r_sum;
   logic                     warm, run_clr, run_inc, det;
   logic [RUN_W-1:0]         run;

   assign advance  = !o_tvalid || o_tready;      // whole pipe moves together
   assign i_tready = advance;
   assign accept   = i_tvalid && advance;
   assign s2_en    = advance && s1_valid;
   assign s3_en    = advance && s2_valid;        // one sample reaches the detector
   assign o_detect = det && o_tvalid;

   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         o_tvalid <= 1'b0;
      end else if (advance) begin
         s1_valid <= i_tvalid;
         s2_valid <= s1_valid;
         o_tvalid <= s2_valid;
      end
   end

   // sample and tlast ride alongside the arithmetic
   always_ff @(posedge clk) begin
      if (accept) begin
         s1_data <= i_tdata;
         s1_last <= i_tlast;
      end
      if (s2_en) begin
         s2_data <= s1_data;
         s2_last <= s1_last;
      end
      if (s3_en) begin
         o_tdata <= s2_data;
         o_tlast <= s2_last;
      end
   end

   sc_delay_line delay_line_inst (.clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_en(accept), .i_tdata(i_tdata), .o_tdata(dly_data));

   sc_corr_power corr_power_inst (.clk(clk), .i_rst_n(i_rst_n), .i_en(accept),
      .i_cur(i_tdata), .i_dly(dly_data), .o_corr_i(corr_i), .o_corr_q(corr_q), .o_pow(pow));

   sc_moving_sum #(.WIDTH(PROD_W)) sum_p_i_inst (.clk(clk), .i_rst_n(i_rst_n),
      .i_clear(i_clear), .i_en(s2_en), .i_data(corr_i), .o_sum(p_i));

   sc_moving_sum #(.WIDTH(PROD_W)) sum_p_q_inst (.clk(clk), .i_rst_n(i_rst_n),
      .i_clear(i_clear), .i_en(s2_en), .i_data(corr_q), .o_sum(p_q));

   sc_moving_sum #(.WIDTH(PROD_W)) sum_r_inst (.clk(clk), .i_rst_n(i_rst_n),
      .i_clear(i_clear), .i_en(s2_en), .i_data(pow), .o_sum(r_sum));

   sc_sample_counter sample_counter_inst (.clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_beat(s3_en), .i_run_clr(run_clr), .i_run_inc(run_inc), .o_warm(warm), .o_run(run));

   sc_detect_fsm detect_fsm_inst (.clk(clk), .i_rst_n(i_rst_n), .i_clear(i_clear),
      .i_en(s3_en), .i_p_i(p_i), .i_p_q(p_q), .i_r(r_sum), .i_warm(warm), .i_run(run),
      .o_run_clr(run_clr), .o_run_inc(run_inc), .o_detect(det));

endmodule

// ==== verif/schmidl_cox_chk.sv ====
module schmidl_cox_chk
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
(
   input logic              clk,
   input logic              i_rst_n,
   input logic              i_clear,
   input logic              i_out_valid,
   input logic              i_out_ready,
   input logic [WORD_W-1:0] i_out_data,
   input logic              i_out_detect,
   input det_state_t        i_state
);
   timeunit 1ns;
   timeprecision 1ps;

   int   gap;                                 // output beats since the last flag
   logic seen;

   always @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         gap  <= 0;
         seen <= 1'b0;
      end else if (i_out_valid && i_out_ready) begin
         gap  <= i_out_detect ? 0 : gap + 1;
         seen <= seen || i_out_detect;
      end
   end

   stall_holds: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data))
      else $error("output beat changed while stalled");

   // the FSM enters HOLD on the same edge that registers the flag
   detect_in_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_out_detect |-> i_out_valid && i_state == HOLD)
      else $error("o_detect high without o_tvalid or outside HOLD");

   // a second flag must wait out the holdoff and a new plateau
   holdoff_spacing: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
      i_out_valid && i_out_ready && i_out_detect && seen |-> gap >= HOLDOFF_LEN)
      else $error("two detections closer than the holdoff");

endmodule

// ==== verif/sc_scoreboard.sv ====
module sc_scoreboard
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,
   input  logic [WORD_W-1:0] i_in_data,
   input  logic              i_in_last,
   input  logic              i_in_valid,
   input  logic              i_in_ready,
   input  logic [WORD_W-1:0] i_out_data,
   input  logic              i_out_last,
   input  logic              i_out_valid,
   input  logic              i_out_ready,
   input  logic              i_out_detect,
   input  logic              i_lat_chk,
   output int                o_errors,
   output int                o_checks,
   output int                o_detects,
   output int                o_pending
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [WORD_W-1:0] pend_data [$];
   logic              pend_last [$];
   longint            pend_cyc [$];
   logic [WORD_W-1:0] hist [$];              // every sample since reset or clear
   det_state_t        st;
   int                run;
   longint            cyc;

   function automatic longint re_part(logic [WORD_W-1:0] w);
      return longint'($signed(w[I_HI:I_LO]));
   endfunction

   function automatic longint im_part(logic [WORD_W-1:0] w);
      return longint'($signed(w[Q_HI:Q_LO]));
   endfunction

   task automatic check_output();
      logic [WORD_W-1:0] w;
      logic [WORD_W-1:0] d;
      logic              last;
      logic              above;
      logic              exp_det;
      longint            stamp, pi, pq, r, ci, cq, di, dq, lhs, rhs;
      int                n;
      if (pend_data.size() == 0) begin
         $display("Fail at %0t ns: output beat with no accepted input", $time);
         o_errors++;
         return;
      end
      w = pend_data.pop_front();
      last = pend_last.pop_front();
      stamp = pend_cyc.pop_front();
      hist.push_back(w);
      n = hist.size() - 1;
      pi = 0;
      pq = 0;
      r = 0;
      for (int k = (n >= WINDOW_LEN - 1) ? n - WINDOW_LEN + 1 : 0; k <= n; k++) begin
         d  = (k >= DELAY_LEN) ? hist[k - DELAY_LEN] : '0;
         ci = re_part(hist[k]);
         cq = im_part(hist[k]);
         di = re_part(d);
         dq = im_part(d);
         pi += ci * di + cq * dq;            // cur times conj(delayed)
         pq += cq * di - ci * dq;
         r  += ci * ci + cq * cq;
      end
      pi = pi >>> METRIC_SHIFT;
      pq = pq >>> METRIC_SHIFT;
      r  = r >>> METRIC_SHIFT;
      lhs = (pi * pi + pq * pq) * THRESH_DEN;
      rhs = r * r * THRESH_NUM;
      above = (n >= WARMUP_LEN) && (lhs >= rhs);
      exp_det = 1'b0;
      case (st)
         SEARCH: if (above) begin
            st = PLATEAU;
            run = 1;
         end
         PLATEAU: if (!above) begin
            st = SEARCH;
            run = 0;
         end else if (run == PLATEAU_MIN - 1) begin
            st = HOLD;
            run = 0;
            exp_det = 1'b1;
         end else begin
            run++;
         end
         default: if (run == HOLDOFF_LEN - 1) begin
            st = SEARCH;
            run = 0;
         end else begin
            run++;
         end
      endcase
      o_checks++;
      if (i_out_data !== w || i_out_last !== last || i_out_detect !== exp_det) begin
         $display("Fail at %0t ns: sample %0d got %h/%b/%b, expected %h/%b/%b", $time, n,
            i_out_data, i_out_last, i_out_detect, w, last, exp_det);
         o_errors++;
      end
      if (i_out_detect === 1'b1)
         o_detects++;
      if (i_lat_chk && cyc - stamp != 3) begin
         $display("Fail at %0t ns: sample %0d latency %0d cycles", $time, n, cyc - stamp);
         o_errors++;
      end
   endtask

   initial begin
      o_errors = 0;
      o_checks = 0;
      o_detects = 0;
      o_pending = 0;
      cyc = 0;
      st = SEARCH;
      run = 0;
   end

   // pre-edge values of the handshake decide what transferred at this edge
   always @(posedge clk) begin
      cyc++;
      if (!i_rst_n || i_clear) begin
         pend_data.delete();
         pend_last.delete();
         pend_cyc.delete();
         hist.delete();
         st = SEARCH;
         run = 0;
      end else begin
         if (i_out_valid && i_out_ready)
            check_output();
         if (i_in_valid && i_in_ready) begin
            pend_data.push_back(i_in_data);
            pend_last.push_back(i_in_last);
            pend_cyc.push_back(cyc);
         end
      end
      o_pending = pend_data.size();
   end

endmodule

// ==== verif/schmidl_cox_tb.sv ====
module schmidl_cox_tb
   import sc_fmt_pkg::*, sc_cfg_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   // back-pressure beats are weighted by 4 for the random stalls
   localparam int TOTAL_BEATS = 40 + 224 + 384 + 4 * 200 + 160 + 64;
   localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 200;

   logic              clk, rst_n, clear;
   logic [WORD_W-1:0] in_data, out_data;
   logic              in_last, in_valid, in_ready;
   logic              out_last, out_valid, out_ready, out_detect;
   logic              lat_chk, bp_mode;
   int                sb_errors, sb_checks, sb_detects, sb_pending;
   int                tb_errors, cycles, det_mark, err_mark;

   schmidl_cox schmidl_cox_inst (.clk(clk), .i_rst_n(rst_n), .i_clear(clear),
      .i_tdata(in_data), .i_tlast(in_last), .i_tvalid(in_valid), .i_tready(in_ready),
      .o_tdata(out_data), .o_tlast(out_last), .o_tvalid(out_valid), .o_tready(out_ready),
      .o_detect(out_detect));

   sc_scoreboard scoreboard_inst (.clk(clk), .i_rst_n(rst_n), .i_clear(clear),
      .i_in_data(in_data), .i_in_last(in_last), .i_in_valid(in_valid),
      .i_in_ready(in_ready), .i_out_data(out_data), .i_out_last(out_last),
      .i_out_valid(out_valid), .i_out_ready(out_ready), .i_out_detect(out_detect),
      .i_lat_chk(lat_chk), .o_errors(sb_errors), .o_checks(sb_checks),
      .o_detects(sb_detects), .o_pending(sb_pending));

   bind schmidl_cox schmidl_cox_chk chk_inst (.clk(clk), .i_rst_n(i_rst_n),
      .i_clear(i_clear), .i_out_valid(o_tvalid), .i_out_ready(o_tready),
      .i_out_data(o_tdata), .i_out_detect(o_detect), .i_state(detect_fsm_inst.state_q));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
   end

   // drives one beat until the DUT takes it with random gaps and stalls in bp_mode
   task automatic send_word(input logic [WORD_W-1:0] word, input logic last);
      logic done;
      logic raised;                            // valid stays up until the transfer
      done = 1'b0;
      raised = 1'b0;
      while (!done) begin
         @(negedge clk);
         out_ready = bp_mode ? ($urandom % 4 != 0) : 1'b1;
         if (!raised)
            raised = bp_mode ? ($urandom % 2 == 0) : 1'b1;
         in_valid  = raised;
         in_data   = word;
         in_last   = last;
         #1;
         done = in_valid && in_ready;
      end
   endtask

   task automatic send_noise(input int len);
      for (int k = 0; k < len; k++)
         send_word($urandom, (k == len - 1));
   endtask

   // period of DELAY_LEN so each half matches the one before it
   task automatic send_preamble(input int len);
      logic [WORD_W-1:0] half [DELAY_LEN];
      foreach (half[k])
         half[k] = $urandom;
      for (int k = 0; k < len; k++)
         send_word(half[k % DELAY_LEN], 1'b0);
   endtask

   task automatic drain();
      @(negedge clk);
      in_valid = 1'b0;
      out_ready = 1'b1;
      while (sb_pending != 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
   endtask

   task automatic need_detects(input string name, input int min_cnt);
      if (sb_detects - det_mark < min_cnt) begin
         $display("%s: expected at least %0d detections, saw %0d", name, min_cnt,
            sb_detects - det_mark);
         tb_errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s: %s, %0d checks so far", name,
         (sb_errors + tb_errors == err_mark) ? "ok" : "FAILED", sb_checks);
      err_mark = sb_errors + tb_errors;
      det_mark = sb_detects;
   endtask

   initial begin
      void'($urandom(61));
      rst_n = 1'b0;
      clear = 1'b0;
      in_data = '0;
      in_last = 1'b0;
      in_valid = 1'b0;
      out_ready = 1'b1;
      lat_chk = 1'b0;
      bp_mode = 1'b0;
      tb_errors = 0;
      err_mark = 0;
      det_mark = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      for (int k = 0; k < 40; k++)
         send_word($urandom, ($urandom % 8 == 0));
      drain();
      end_test("pass-through");

      send_noise(64);
      send_preamble(96);
      send_noise(64);
      drain();
      need_detects("preamble", 1);
      end_test("preamble");

      send_noise(32);
      send_preamble(320);
      send_noise(32);
      drain();
      need_detects("holdoff", 2);
      end_test("holdoff");

      bp_mode = 1'b1;
      send_noise(40);
      send_preamble(96);
      send_noise(64);
      bp_mode = 1'b0;
      drain();
      end_test("back-pressure");

      send_noise(48);
      drain();
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      det_mark = sb_detects;
      send_preamble(96);
      send_noise(16);
      drain();
      need_detects("clear", 1);
      end_test("clear");

      lat_chk = 1'b1;
      send_noise(64);
      drain();
      lat_chk = 1'b0;
      end_test("latency");

      $display("checks %0d, scoreboard errors %0d, test errors %0d", sb_checks, sb_errors,
         tb_errors);
      if (sb_errors + tb_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== project.f ====
design/sc_fmt_pkg.sv
design/sc_cfg_pkg.sv
design/sc_delay_line.sv
design/sc_corr_power.sv
design/sc_moving_sum.sv
design/sc_sample_counter.sv
design/sc_detect_fsm.sv
design/schmidl_cox.sv
verif/schmidl_cox_chk.sv
verif/sc_scoreboard.sv
verif/schmidl_cox_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = schmidl_cox_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
